/* testbench/tetris_stim.txt */
// One hex word per command: cmd, column, row, color (one digit each)
// cmd 1 write (column f = whole row, color f = random), 2 tick (low 3 digits = count)
// cmd 3 checks a frame, 0 ends the list
3000
1354
1f4f
1fbf
10b6
1faf
3000
1f03
2005
1205
3000
212c
3000
0000

/* tetris.f */
+incdir+verilog
verilog/tetris_pkg.sv
verilog/pixel_source.sv
verilog/credit_fifo.sv
verilog/vga_scanout.sv
verilog/tetris_top.sv
testbench/tetris_sva.sv
testbench/tetris_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the tetris testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tetris_tb -f tetris.f -o tetris_sim \
  && ./obj_dir/tetris_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

/* testbench/tetris_tb.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tetris_tb
  import tetris_pkg::*;
();

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int GRID_ROWS = `V_ACTIVE - 1;
  localparam int STIM_DEPTH = 64;

  logic     onehuzz = 1'b0;
  logic     reset;
  grid_wr_t grid_wr;
  logic     score_tick;
  logic     red;
  logic     green;
  logic     blue;
  logic     hsync;
  logic     vsync;
  logic     active;

  // Command words from the stim file
  logic [15:0] stim [STIM_DEPTH];
  // Reference copies of the playfield and score
  logic [2:0]  model_grid [GRID_ROWS][`H_ACTIVE];
  int          model_score;
  int          seed = 32'h444d;
  int          limit_ns = 0;

  tetris_top dut0 (
    .onehuzz   (onehuzz),
    .reset     (reset),
    .grid_wr   (grid_wr),
    .score_tick(score_tick),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hsync     (hsync),
    .vsync     (vsync),
    .active    (active)
  );

  // 8 ns clock
  always #4 onehuzz = ~onehuzz;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, int actual, int expected);
    if (actual != expected) begin
      abort_run($sformatf("Error at %0t: %s = %0d, expected %0d", $time, name, actual,
                          expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic drive_inputs(logic valid, int col, int row, int color, logic tick);
    @(posedge onehuzz);
    #1;
    grid_wr    = grid_wr_t'({valid, col[3:0], row[3:0], color[2:0]});
    score_tick = tick;
  endtask

  // Column 15 means the whole row, color 15 a random color per cell
  task automatic run_write(int col, int row, int color);
    int c;
    int pick;
    for (c = 0; c < `H_ACTIVE; c++) begin
      if (col == 15 || col == c) begin
        pick = (color == 15) ? ($random(seed) & 7) : color;
        drive_inputs(1'b1, c, row, pick, 1'b0);
        model_grid[row][c] = pick[2:0];
      end
    end
  endtask

  // Returns on the first low sample after a vsync pulse
  task automatic wait_vsync_end();
    logic seen;
    seen = 1'b0;
    while (!(seen && !vsync)) begin
      @(negedge onehuzz);
      if (vsync) begin
        seen = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference frame and frame compare
  //////////////////////////////////////////////////////////////////////

  function automatic int expected_color(int x, int y);
    // Set score bits cover the grid, MSB leftmost
    if (y == 0 && x < 8 && ((model_score >> (7 - x)) & 1) == 1) begin
      return 7;
    end
    // Screen row 0 repeats grid row 0
    return int'(model_grid[(y == 0) ? 0 : y - 1][x]);
  endfunction

  // Samples on the falling edge, runs up to the end of the next vsync
  task automatic compare_frame();
    int   idx;
    int   cyc;
    int   first;
    int   rgb;
    int   n_hsync;
    logic prev_h;
    logic prev_v;
    logic done;
    idx     = 0;
    cyc     = 0;
    first   = -1;
    n_hsync = 0;
    prev_h  = 1'b0;
    prev_v  = 1'b0;
    done    = 1'b0;
    while (!done) begin
      @(negedge onehuzz);
      rgb = int'({red, green, blue});
      if (active) begin
        if (idx >= `H_ACTIVE * `V_ACTIVE) begin
          abort_run("More active pixels in one frame than the screen holds");
        end
        // First active pixel anchors the sync offsets
        if (first < 0) begin
          first = cyc;
        end
        check_value($sformatf("rgb(x=%0d,y=%0d)", idx % `H_ACTIVE, idx / `H_ACTIVE), rgb,
                    expected_color(idx % `H_ACTIVE, idx / `H_ACTIVE));
        idx++;
      end else begin
        check_value("rgb_blank", rgb, 0);
      end
      if (hsync && !prev_h && first >= 0) begin
        check_value("hsync_offset", (cyc - first) % H_TOTAL, `H_ACTIVE + `H_FRONT);
        n_hsync++;
      end
      if (vsync && !prev_v) begin
        check_value("vsync_offset", cyc - first, (`V_ACTIVE + `V_FRONT) * H_TOTAL);
      end
      done   = prev_v && !vsync;
      prev_h = hsync;
      prev_v = vsync;
      cyc++;
    end
    // Nothing lost or repeated in the buffer
    check_value("active_count", idx, `H_ACTIVE * `V_ACTIVE);
    // One hsync per line from the first visible line through the vsync lines
    check_value("hsync_count", n_hsync, `V_ACTIVE + `V_FRONT + `V_SYNC);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int k;
    int n_checks;
    logic [15:0] word;
    reset       = 1'b1;
    score_tick  = 1'b0;
    grid_wr     = '0;
    model_score = 0;
    $readmemh("testbench/tetris_stim.txt", stim);
    n_checks = 0;
    for (i = 0; i < STIM_DEPTH && stim[i][15:12] != 4'h0; i++) begin
      if (stim[i][15:12] == 4'h3) begin
        n_checks++;
      end
    end
    limit_ns = (n_checks + 2) * 3 * FRAME_CYCLES * 8;
    repeat (10) @(posedge onehuzz);
    #1;
    reset = 1'b0;
    // Grid memory powers up unknown, start from black
    for (i = 0; i < GRID_ROWS; i++) begin
      run_write(15, i, 0);
    end
    drive_inputs(1'b0, 0, 0, 0, 1'b0);
    wait_vsync_end();
    for (i = 0; i < STIM_DEPTH && stim[i][15:12] != 4'h0; i++) begin
      word = stim[i];
      case (word[15:12])
        4'h1: run_write(int'(word[11:8]), int'(word[7:4]), int'(word[3:0]));
        4'h2: begin
          for (k = 0; k < int'(word[11:0]); k++) begin
            drive_inputs(1'b0, 0, 0, 0, 1'b1);
            // Score saturates at 255
            if (model_score < 255) begin
              model_score = model_score + 1;
            end
          end
        end
        4'h3: begin
          drive_inputs(1'b0, 0, 0, 0, 1'b0);
          // Skip the frame that may still hold old pixels
          wait_vsync_end();
          compare_frame();
        end
        default: abort_run($sformatf("Unknown stim command %h in word %0d", word, i));
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

  // Watchdog sized from the number of frame checks
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    abort_run("Watchdog expired before the stimulus finished");
  end

endmodule

/* testbench/tetris_sva.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tetris_sva
  import tetris_pkg::*;
#(
  parameter int HW = $clog2(`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK),
  parameter int VW = $clog2(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK),
  parameter int NW = $clog2(`FIFO_DEPTH + 1)
) (
  input logic          onehuzz,
  input logic          reset,
  input logic          push,
  input logic [NW-1:0] count,
  input logic          credit,
  input logic          pop,
  input logic          running,
  input logic          visible,
  input logic [HW-1:0] h,
  input logic [VW-1:0] v,
  input pixel_t        pop_data
);

  //////////////////////////////////////////////////////////////////////
  // Credit loop
  //////////////////////////////////////////////////////////////////////

  // A push with no credit left would land on a full buffer
  a_push_room: assert property (@(posedge onehuzz) disable iff (reset)
    push |-> int'(count) < `FIFO_DEPTH)
    else $error("push while the buffer is full");

  // Entries plus pushes and credits in flight
  a_credit_sum: assert property (@(posedge onehuzz) disable iff (reset)
    int'(count) + int'(push) + int'(credit) <= `FIFO_DEPTH)
    else $error("more entries and credits than buffer depth");

  //////////////////////////////////////////////////////////////////////
  // Frame alignment
  //////////////////////////////////////////////////////////////////////

  a_line_end: assert property (@(posedge onehuzz) disable iff (reset)
    pop |-> pop_data.line_end == (int'(h) == `H_ACTIVE - 1))
    else $error("line_end off the last pixel of a line");

  a_frame_end: assert property (@(posedge onehuzz) disable iff (reset)
    pop |-> pop_data.frame_end == (int'(h) == `H_ACTIVE - 1 && int'(v) == `V_ACTIVE - 1))
    else $error("frame_end off the last visible pixel");

  // Once started, every visible position pops and blanking never does
  a_pop_visible: assert property (@(posedge onehuzz) disable iff (reset)
    running |-> pop == visible)
    else $error("pop missing in the visible area or present in blanking");

endmodule

// Buffer side, scanout ports tied off
bind credit_fifo tetris_sva sva_buf (
  .onehuzz(onehuzz), .reset(reset), .push(push), .count(count), .credit(credit),
  .pop(1'b0), .running(1'b0), .visible(1'b0), .h('0), .v('0), .pop_data('0)
);

// Scanout side, buffer ports tied off
bind vga_scanout tetris_sva sva_scan (
  .onehuzz(onehuzz), .reset(reset), .push(1'b0), .count('0), .credit(1'b0),
  .pop(pop), .running(running), .visible(visible), .h(h), .v(v), .pop_data(pop_data)
);

/* verilog/tetris_top.sv */
`timescale 1ns/1ps

module tetris_top
  import tetris_pkg::*;
(
  input  logic     onehuzz,
  input  logic     reset,
  input  grid_wr_t grid_wr,
  input  logic     score_tick,
  output logic     red,
  output logic     green,
  output logic     blue,
  output logic     hsync,
  output logic     vsync,
  output logic     active
);

  // Source to buffer
  logic   push;
  pixel_t push_data;
  logic   credit;
  // Buffer to scanout
  logic   pop;
  pixel_t pop_data;
  logic   not_empty;

  //////////////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  //////////////////////////////////////////////////////////////////////

  pixel_source src0 (
    .onehuzz   (onehuzz),
    .reset     (reset),
    .grid_wr   (grid_wr),
    .score_tick(score_tick),
    .credit    (credit),
    .push      (push),
    .push_data (push_data)
  );

  credit_fifo #(.payload_t(pixel_t)) buf0 (
    .onehuzz  (onehuzz),
    .reset    (reset),
    .push     (push),
    .push_data(push_data),
    .pop      (pop),
    .pop_data (pop_data),
    .not_empty(not_empty),
    .credit   (credit)
  );

  vga_scanout scan0 (
    .onehuzz  (onehuzz),
    .reset    (reset),
    .pop_data (pop_data),
    .not_empty(not_empty),
    .pop      (pop),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .hsync    (hsync),
    .vsync    (vsync),
    .active   (active)
  );

endmodule

/* verilog/vga_scanout.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module vga_scanout
  import tetris_pkg::*;
(
  input  logic   onehuzz,
  input  logic   reset,
  input  pixel_t pop_data,
  input  logic   not_empty,
  output logic   pop,
  output logic   red,
  output logic   green,
  output logic   blue,
  output logic   hsync,
  output logic   vsync,
  output logic   active
);

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int HW = $clog2(H_TOTAL);
  localparam int VW = $clog2(V_TOTAL);

  // Counter landmarks
  localparam logic [HW-1:0] H_VIS_END    = HW'(`H_ACTIVE);
  localparam logic [HW-1:0] H_SYNC_START = HW'(`H_ACTIVE + `H_FRONT);
  localparam logic [HW-1:0] H_SYNC_END   = HW'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam logic [HW-1:0] H_LAST       = HW'(H_TOTAL - 1);
  localparam logic [VW-1:0] V_VIS_END    = VW'(`V_ACTIVE);
  localparam logic [VW-1:0] V_SYNC_START = VW'(`V_ACTIVE + `V_FRONT);
  localparam logic [VW-1:0] V_SYNC_END   = VW'(`V_ACTIVE + `V_FRONT + `V_SYNC);
  localparam logic [VW-1:0] V_LAST       = VW'(V_TOTAL - 1);

  logic [HW-1:0] h;
  logic [VW-1:0] v;
  // Set once the first pixel is taken
  logic          running;
  logic          visible;
  logic          h_in_sync;
  logic          v_in_sync;
  logic [2:0]    rgb;

  //////////////////////////////////////////////////////////////////////
  // Timing decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    visible   = (h < H_VIS_END) && (v < V_VIS_END);
    h_in_sync = (h >= H_SYNC_START) && (h < H_SYNC_END);
    v_in_sync = (v >= V_SYNC_START) && (v < V_SYNC_END);
    // Before start the counters rest on pixel 0, so this also waits for data
    pop       = visible && not_empty;
    rgb       = pop_data.color;
  end

  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      h       <= '0;
      v       <= '0;
      running <= 1'b0;
      red     <= 1'b0;
      green   <= 1'b0;
      blue    <= 1'b0;
      hsync   <= 1'b0;
      vsync   <= 1'b0;
      active  <= 1'b0;
    end else begin
      if (pop) begin
        running <= 1'b1;
      end
      // Free running once started
      if (running || pop) begin
        h <= (h == H_LAST) ? '0 : h + 1'b1;
        if (h == H_LAST) begin
          v <= (v == V_LAST) ? '0 : v + 1'b1;
        end
      end
      // Outputs lag the pop by one cycle, black in blanking
      active <= pop;
      red    <= pop && rgb[2];
      green  <= pop && rgb[1];
      blue   <= pop && rgb[0];
      hsync  <= running && h_in_sync;
      vsync  <= running && v_in_sync;
    end
  end

endmodule

/* verilog/credit_fifo.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module credit_fifo
  import tetris_pkg::*;
#(
  parameter type payload_t = pixel_t
) (
  input  logic     onehuzz,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     credit
);

  localparam int PW = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
  localparam int NW = $clog2(`FIFO_DEPTH + 1);
  localparam logic [PW-1:0] PTR_LAST = PW'(`FIFO_DEPTH - 1);

  payload_t      mem [`FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  // Entries currently held
  logic [NW-1:0] count;
  logic          do_pop;

  assign not_empty = (count != '0);
  // Pops on an empty buffer are ignored
  assign do_pop    = pop && not_empty;
  // Head entry, shows one cycle after its push
  assign pop_data  = mem[rd_ptr];

  // Storage, payload is never inspected
  always_ff @(posedge onehuzz) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers, fill level and credit return
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count + NW'(push) - NW'(do_pop);
      // One credit back per pop, a cycle later
      credit <= do_pop;
    end
  end

endmodule

/* verilog/pixel_source.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module pixel_source
  import tetris_pkg::*;
(
  input  logic     onehuzz,
  input  logic     reset,
  input  grid_wr_t grid_wr,
  input  logic     score_tick,
  input  logic     credit,
  output logic     push,
  output pixel_t   push_data
);

  localparam int GRID_ROWS = `V_ACTIVE - 1;
  localparam int XW = $clog2(`H_ACTIVE);
  localparam int YW = $clog2(`V_ACTIVE);
  localparam int CW = $clog2(`FIFO_DEPTH + 1);
  localparam logic [XW-1:0] X_LAST = XW'(`H_ACTIVE - 1);
  localparam logic [YW-1:0] Y_LAST = YW'(`V_ACTIVE - 1);
  localparam logic [CW-1:0] CREDIT_INIT = CW'(`FIFO_DEPTH);

  // Playfield, one color per cell
  color_t        grid_mem [GRID_ROWS][`H_ACTIVE];
  // Raster position of the next pixel to send
  logic [XW-1:0] x;
  logic [YW-1:0] y;
  logic [CW-1:0] credit_cnt;
  logic [7:0]    score;
  logic [7:0]    frame_score;
  logic [7:0]    shown_score;
  logic          take;
  logic          last_x;
  logic          last_y;
  logic [YW-1:0] grid_y;
  color_t        cell_color;
  color_t        pix_color;

  //////////////////////////////////////////////////////////////////////
  // Grid memory and score
  //////////////////////////////////////////////////////////////////////

  // Writes outside the playfield are dropped
  always_ff @(posedge onehuzz) begin
    if (grid_wr.valid && int'(grid_wr.row) < GRID_ROWS && int'(grid_wr.col) < `H_ACTIVE) begin
      grid_mem[grid_wr.row][grid_wr.col] <= grid_wr.color;
    end
  end

  // Saturating score, stops at 255
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      score <= 8'd0;
    end else if (score_tick && score != 8'hff) begin
      score <= score + 8'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pixel lookup
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Send whenever a credit is held or one is coming back now
    take   = (credit_cnt != '0) || credit;
    last_x = (x == X_LAST);
    last_y = (y == Y_LAST);
    // Screen row r+1 shows grid row r, row 0 repeats grid row 0
    grid_y = (y == '0) ? '0 : y - 1'b1;
    cell_color = grid_mem[grid_y][x];
    // Fresh score copy on the first pixel of the frame
    shown_score = (x == '0 && y == '0) ? score : frame_score;
    pix_color = cell_color;
    // Score MSB on the left, ~x picks bit 7-x
    if (y == '0 && x < XW'(8) && shown_score[~x[2:0]]) begin
      pix_color = WHITE;
    end
  end

  // Raster walk and credit bookkeeping
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      x           <= '0;
      y           <= '0;
      credit_cnt  <= CREDIT_INIT;
      push        <= 1'b0;
      frame_score <= 8'd0;
    end else begin
      push       <= take;
      credit_cnt <= credit_cnt + CW'(credit) - CW'(take);
      if (take) begin
        if (x == '0 && y == '0) begin
          frame_score <= score;
        end
        x <= last_x ? '0 : x + 1'b1;
        if (last_x) begin
          y <= last_y ? '0 : y + 1'b1;
        end
      end
    end
  end

  // Payload register
  always_ff @(posedge onehuzz) begin
    if (take) begin
      push_data <= '{color: pix_color, line_end: last_x, frame_end: last_x && last_y};
    end
  end

endmodule

/* verilog/tetris_pkg.sv */
package tetris_pkg;

  //////////////////////////////////////////////////////////////////////
  // Colors
  //////////////////////////////////////////////////////////////////////

  // Bit 2 red, bit 1 green, bit 0 blue
  typedef enum logic [2:0] {
    BLACK   = 3'b000,
    BLUE    = 3'b001,
    GREEN   = 3'b010,
    CYAN    = 3'b011,
    RED     = 3'b100,
    MAGENTA = 3'b101,
    YELLOW  = 3'b110,
    WHITE   = 3'b111
  } color_t;

  // One pixel on its way to the scanout
  typedef struct packed {
    color_t color;
    // Last pixel of a line
    logic   line_end;
    // Last pixel of a frame
    logic   frame_end;
  } pixel_t;

  // Single grid cell write
  typedef struct packed {
    logic       valid;
    logic [3:0] col;
    logic [3:0] row;
    color_t     color;
  } grid_wr_t;

endpackage

/* verilog/tetris_cfg.svh */
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Screen geometry
//////////////////////////////////////////////////////////////////////

// Visible pixels per line
`define H_ACTIVE 16
// Visible lines per frame, row 0 holds the score
`define V_ACTIVE 13

// Horizontal blanking, in pixel clocks
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 2

// Vertical blanking, in lines
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1

// Pixel buffer depth, also the starting credit count of the source
`define FIFO_DEPTH 4

`endif
